// File: sources.f
+incdir+.
sdram_cmd_pkg.sv
sdram_req_pkg.sv
sdram_refresh_timer.sv
sdram_sequencer.sv
sdram_cmd_out.sv
sdram_read_capture.sv
sdram_ctrl.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

// File: tb_sdram_ctrl.sv
`default_nettype none

`include "sdram_defines.svh"

module tb_sdram_ctrl;
	timeunit 1ns;
	timeprecision 1ps;
	import sdram_cmd_pkg::*;
	import sdram_req_pkg::*;

	localparam int n_trans        = 400;
	localparam int timeout_cycles = `SDRAM_STARTUP_CYCLES + n_trans * 20 + 1000;
	localparam int rd_latency     = 8;   // accept edge to rsp_valid
	localparam int min_refreshes  = 6;   // two at startup and four more during the run

	logic        clk;
	logic        arst_n;
	logic        req_valid;
	logic        req_ready;
	logic        req_write;
	word_addr_t  req_addr;
	word_t       req_wdata;
	byte_en_t    req_be;
	logic        rsp_valid;
	word_t       rsp_rdata;
	logic        cs_n;
	logic        ras_n;
	logic        cas_n;
	logic        we_n;
	logic [12:0] a;
	bank_t       ba;
	logic [1:0]  dqm;
	wire  [15:0] dq;
	int          model_errors;
	int          refresh_count;
	logic        init_seen;

	integer      seed;
	int          errors;
	int          cycle;
	int          reads_accepted;
	int          reads_returned;
	int          writes_accepted;
	word_t       ref_mem [word_addr_t];
	word_t       exp_data_q [$];
	word_addr_t  exp_addr_q [$];
	int          exp_edge_q [$];

	sdram_ctrl i_sdram_ctrl (
		.clk (clk), .arst_n (arst_n),
		.req_valid (req_valid), .req_ready (req_ready), .req_write (req_write),
		.req_addr (req_addr), .req_wdata (req_wdata), .req_be (req_be),
		.rsp_valid (rsp_valid), .rsp_rdata (rsp_rdata),
		.cs_n (cs_n), .ras_n (ras_n), .cas_n (cas_n), .we_n (we_n),
		.a (a), .ba (ba), .dqm (dqm), .dq (dq)
	);

	tb_sdram_model i_model (
		.clk (clk), .arst_n (arst_n),
		.cs_n (cs_n), .ras_n (ras_n), .cas_n (cas_n), .we_n (we_n),
		.a (a), .ba (ba), .dqm (dqm), .dq (dq),
		.error_count (model_errors), .refresh_count (refresh_count), .init_seen (init_seen)
	);

	always #50 clk = ~clk;

	function automatic half_t fill_half(input logic [23:0] ha);
		return ha[15:0] ^ {ha[23:16], ha[23:16]} ^ 16'hc3a5;
	endfunction

	// word address {row, bank, col word} maps to device half {bank, row, col word, half}
	function automatic word_t mem_word(input word_addr_t wa);
		logic [23:0] ha;
		ha = {wa[9:8], wa[22:10], wa[7:0], 1'b0};
		if (ref_mem.exists(wa))
			return ref_mem[wa];
		return {fill_half(ha | 24'd1), fill_half(ha)};
	endfunction

	function automatic word_t merge_bytes(input word_t old, input word_t data, input byte_en_t be);
		word_t res;
		res = old;
		for (int i = 0; i < 4; i++)
			if (be[i])
				res[8*i +: 8] = data[8*i +: 8];
		return res;
	endfunction

	task automatic print_counts();
		$display("errors: testbench %0d, model %0d (reads %0d/%0d, writes %0d, refreshes %0d)",
			errors, model_errors, reads_returned, reads_accepted, writes_accepted, refresh_count);
	endtask

	task automatic check_response();
		word_t      exp;
		word_addr_t addr;
		int         edge_no;
		if (exp_data_q.size() == 0) begin
			errors++;
			$display("rsp_valid with no read outstanding at cycle %0d", cycle);
		end else begin
			exp     = exp_data_q.pop_front();
			addr    = exp_addr_q.pop_front();
			edge_no = exp_edge_q.pop_front();
			reads_returned++;
			if (cycle - edge_no != rd_latency) begin
				errors++;
				$display("Error rsp_valid latency: expected 0x%h, got 0x%h", rd_latency,
					cycle - edge_no);
			end
			if (rsp_rdata !== exp) begin
				errors++;
				$display("Error rsp_rdata at 0x%h: expected 0x%h, got 0x%h", addr, exp, rsp_rdata);
			end
		end
	endtask

	// -----------------------------------------------------------------------
	// cycle count and run limit
	// -----------------------------------------------------------------------

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles) begin
			$display("timeout: run did not finish within %0d cycles", timeout_cycles);
			print_counts();
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// accept and response monitor on the falling edge
	always @(negedge clk) begin
		if (!init_seen && req_ready) begin
			errors++;
			$display("req_ready high before the startup sequence finished");
		end
		if (arst_n && req_valid && req_ready) begin
			if (req_write) begin
				ref_mem[req_addr] = merge_bytes(mem_word(req_addr), req_wdata, req_be);
				writes_accepted++;
			end else begin
				exp_data_q.push_back(mem_word(req_addr));
				exp_addr_q.push_back(req_addr);
				exp_edge_q.push_back(cycle + 1);   // transfer is on the coming edge
				reads_accepted++;
			end
		end
		if (rsp_valid)
			check_response();
	end

	task automatic random_request();
		logic [31:0] rnd;
		int          gap;
		rnd       = $random(seed);
		req_write = rnd[0];
		req_addr  = {2'b00, rnd[8] ? 9'h1a5 : 9'h000, rnd[2:1], rnd[4:3], 5'b00000, rnd[7:5]};
		req_wdata = $random(seed);
		req_be    = rnd[12:9];
		req_valid = 1'b1;
		gap       = rnd[16:13];
		do @(negedge clk); while (!req_ready);   // held under back-pressure
		@(posedge clk);
		#10;
		rnd       = $random(seed);
		req_valid = 1'b0;
		req_write = rnd[0];
		req_addr  = rnd[23:1];                  // junk while req_valid is low
		req_wdata = $random(seed);
		req_be    = rnd[31:28];
		for (int i = 0; i < gap; i++) begin
			@(posedge clk);
			#10;
		end
	endtask

	initial begin
		seed            = 69154;
		clk             = 1'b0;
		arst_n          = 1'b0;
		req_valid       = 1'b0;
		req_write       = 1'b0;
		req_addr        = '0;
		req_wdata       = '0;
		req_be          = '0;
		errors          = 0;
		cycle           = 0;
		reads_accepted  = 0;
		reads_returned  = 0;
		writes_accepted = 0;
		repeat (10) @(posedge clk);
		#10;
		arst_n = 1'b1;
		do @(negedge clk); while (!req_ready);   // startup done
		@(posedge clk);
		#10;
		repeat (n_trans) random_request();
		while (exp_data_q.size() != 0)
			@(posedge clk);
		repeat (20) @(posedge clk);
		if (!init_seen) begin
			errors++;
			$display("startup sequence never completed");
		end
		if (reads_accepted != reads_returned) begin
			errors++;
			$display("%0d reads accepted but %0d responses returned", reads_accepted,
				reads_returned);
		end
		if (refresh_count < min_refreshes) begin
			errors++;
			$display("only %0d AUTO_REFRESH commands seen, run too short", refresh_count);
		end
		print_counts();
		if (errors == 0 && model_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_sdram_model.sv
`default_nettype none

`include "sdram_defines.svh"

module tb_sdram_model (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 cs_n,
	input  logic                 ras_n,
	input  logic                 cas_n,
	input  logic                 we_n,
	input  logic [12:0]          a,
	input  sdram_cmd_pkg::bank_t ba,
	input  logic [1:0]           dqm,
	inout  wire  [15:0]          dq,
	output int                   error_count,
	output int                   refresh_count,
	output logic                 init_seen
);
	timeunit 1ns;
	timeprecision 1ps;
	import sdram_cmd_pkg::*;

	logic [15:0] mem [logic [23:0]];   // {bank, row, col}, holds written halves only
	row_t        open_row [4];
	logic [3:0]  bank_open;
	logic [2:0]  rd_q;                 // read command, then its two beats
	logic [23:0] rd_addr;
	logic [23:0] wr_addr;
	logic [15:0] wr_half;
	logic [15:0] dq_drv;
	logic        dq_en;
	sdram_cmd_t  cmd;
	int          cycle;
	int          last_rfsh;
	int          last_init;
	int          init_idx;

	assign cmd = cs_n ? CMD_NOP : sdram_cmd_t'({ras_n, cas_n, we_n});
	assign dq  = dq_en ? dq_drv : 16'bz;

	// unwritten locations read back a pattern of their full address
	function automatic logic [15:0] fill_half(input logic [23:0] ha);
		return ha[15:0] ^ {ha[23:16], ha[23:16]} ^ 16'hc3a5;
	endfunction

	function automatic logic [15:0] read_half(input logic [23:0] ha);
		return mem.exists(ha) ? mem[ha] : fill_half(ha);
	endfunction

	task automatic report_problem(input string msg);
		$display("model: %s at cycle %0d", msg, cycle);
		error_count++;
	endtask

	// -----------------------------------------------------------------------
	// power-up order: precharge-all, refresh, refresh, load mode
	// -----------------------------------------------------------------------

	task automatic check_startup();
		if (init_idx == 0 && cycle < `SDRAM_STARTUP_CYCLES - 6 * `SDRAM_INIT_STEP)
			report_problem("first startup command came too soon after reset");
		if (init_idx > 0 && cycle - last_init != `SDRAM_INIT_STEP)
			report_problem("startup commands are not evenly spaced");
		case (init_idx)
			0: if (cmd != CMD_PRECHARGE || !a[10])
				report_problem("first startup command is not a precharge of all banks");
			1, 2: if (cmd != CMD_AUTO_REFRESH)
				report_problem("startup refresh missing or out of order");
			default: begin
				if (cmd != CMD_LOAD_MODE) begin
					report_problem("startup did not end with LOAD_MODE");
				end else if (a != `SDRAM_MODE_VALUE) begin
					$display("Error a: expected 0x%h, got 0x%h", `SDRAM_MODE_VALUE, a);
					error_count++;
				end
				init_seen = 1'b1;
			end
		endcase
		$display("model: startup command %0d, code %b, cycle %0d", init_idx + 1, cmd, cycle);
		if (cmd == CMD_AUTO_REFRESH) begin
			last_rfsh = cycle;
			refresh_count++;
		end
		last_init = cycle;
		init_idx++;
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle         = 0;
			init_idx      = 0;
			init_seen     = 1'b0;
			error_count   = 0;
			refresh_count = 0;
			bank_open     = '0;
			rd_q          = '0;
			last_rfsh     = 0;
			last_init     = 0;
		end else begin
			cycle++;
			rd_q = {rd_q[1:0], cmd == CMD_READ};
			if (!init_seen && cmd != CMD_NOP) begin
				check_startup();
			end else begin
				case (cmd)
					CMD_ACTIVE: begin
						if (bank_open[ba])
							report_problem("ACTIVE to a bank that is already open");
						if (cycle - last_rfsh <= `SDRAM_RFSH_IDLE)
							report_problem("ACTIVE too soon after AUTO_REFRESH");
						open_row[ba]  = a;
						bank_open[ba] = 1'b1;
					end
					CMD_READ: begin
						if (!bank_open[ba])
							report_problem("READ to a closed bank");
						rd_addr = {ba, open_row[ba], a[8:0]};
						if (a[10])
							bank_open[ba] = 1'b0;
					end
					CMD_WRITE: begin
						if (!bank_open[ba])
							report_problem("WRITE to a closed bank");
						wr_addr = {ba, open_row[ba], a[8:0]};
						wr_half = read_half(wr_addr);
						if (!dqm[0])
							wr_half[7:0] = dq[7:0];
						if (!dqm[1])
							wr_half[15:8] = dq[15:8];
						mem[wr_addr] = wr_half;
						if (a[10])
							bank_open[ba] = 1'b0;
					end
					CMD_AUTO_REFRESH: begin
						if (bank_open != '0)
							report_problem("AUTO_REFRESH with a bank still open");
						if (cycle - last_rfsh > `SDRAM_REFRESH_INTERVAL + 12)
							report_problem("gap between AUTO_REFRESH commands is too long");
						last_rfsh = cycle;
						refresh_count++;
					end
					CMD_PRECHARGE: begin
						if (a[10])
							bank_open = '0;
						else
							bank_open[ba] = 1'b0;
					end
					CMD_LOAD_MODE: report_problem("LOAD_MODE after the startup sequence");
					default: ;
				endcase
			end
		end
	end

	// cas latency 2, data changes just after the edge
	always @(posedge clk) begin
		#1;
		dq_en = rd_q[1] || rd_q[2];
		if (dq_en)
			dq_drv = read_half({rd_addr[23:1], rd_q[2]});   // low half first
	end

endmodule

`default_nettype wire

// File: sdram_ctrl.sv
`default_nettype none

module sdram_ctrl (
	input  logic                      clk,
	input  logic                      arst_n,
	// request channel
	input  logic                      req_valid,
	output logic                      req_ready,
	input  logic                      req_write,
	input  sdram_req_pkg::word_addr_t req_addr,
	input  sdram_req_pkg::word_t      req_wdata,
	input  sdram_req_pkg::byte_en_t   req_be,
	// read response
	output logic                      rsp_valid,
	output sdram_req_pkg::word_t      rsp_rdata,
	// SDRAM pins
	output logic                      cs_n,
	output logic                      ras_n,
	output logic                      cas_n,
	output logic                      we_n,
	output logic [12:0]               a,
	output sdram_cmd_pkg::bank_t      ba,
	output logic [1:0]                dqm,
	inout  wire  [15:0]               dq
);
	import sdram_cmd_pkg::*;

	logic       init_done;
	logic [2:0] init_step;
	logic       init_tick;
	logic       refresh_due;
	logic       refresh_taken;

	sdram_cmd_t cmd;
	row_t       row;
	col_t       col;
	bank_t      bank;
	logic       auto_pre;
	logic       write_high;
	logic       read_start;
	logic [1:0] mask;

	sdram_refresh_timer i_timer (
		.clk           (clk),
		.arst_n        (arst_n),
		.refresh_taken (refresh_taken),
		.init_done     (init_done),
		.init_step     (init_step),
		.init_tick     (init_tick),
		.refresh_due   (refresh_due)
	);

	sdram_sequencer i_sequencer (
		.clk           (clk),
		.arst_n        (arst_n),
		.req_valid     (req_valid),
		.req_write     (req_write),
		.req_addr      (req_addr),
		.req_be        (req_be),
		.req_ready     (req_ready),
		.init_done     (init_done),
		.init_tick     (init_tick),
		.init_step     (init_step),
		.refresh_due   (refresh_due),
		.refresh_taken (refresh_taken),
		.cmd           (cmd),
		.row           (row),
		.col           (col),
		.bank          (bank),
		.auto_pre      (auto_pre),
		.write_high    (write_high),
		.read_start    (read_start),
		.mask          (mask)
	);

	sdram_cmd_out i_cmd_out (
		.clk        (clk),
		.arst_n     (arst_n),
		.cmd        (cmd),
		.row        (row),
		.col        (col),
		.bank       (bank),
		.auto_pre   (auto_pre),
		.write_high (write_high),
		.mask       (mask),
		.req_wdata  (req_wdata),
		.cs_n       (cs_n),
		.ras_n      (ras_n),
		.cas_n      (cas_n),
		.we_n       (we_n),
		.a          (a),
		.ba         (ba),
		.dqm        (dqm),
		.dq         (dq)
	);

	sdram_read_capture i_read_capture (
		.clk        (clk),
		.arst_n     (arst_n),
		.read_start (read_start),
		.dq         (dq),
		.rsp_valid  (rsp_valid),
		.rsp_rdata  (rsp_rdata)
	);

endmodule

`default_nettype wire

// File: sdram_read_capture.sv
`default_nettype none

`include "sdram_defines.svh"

module sdram_read_capture (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 read_start,
	input  wire  [15:0]          dq,
	output logic                 rsp_valid,
	output sdram_req_pkg::word_t rsp_rdata
);
	import sdram_req_pkg::*;

	// cas latency plus the pin register and the dq input register
	localparam int delay = `SDRAM_CAS_LATENCY + 2;

	logic [delay:0] rd_pipe;
	half_t          dq_reg;

	// -----------------------------------------------------------------------
	// read_start travels down the line until its beats reach dq_reg
	// -----------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_pipe   <= '0;
			rsp_valid <= 1'b0;
		end else begin
			rd_pipe   <= {rd_pipe[delay-1:0], read_start};
			rsp_valid <= rd_pipe[delay];   // both halves are in by now
		end
	end

	always_ff @(posedge clk) begin
		dq_reg <= dq;
		if (rd_pipe[delay-1])
			rsp_rdata[15:0] <= dq_reg;    // first beat is the low half
		if (rd_pipe[delay])
			rsp_rdata[31:16] <= dq_reg;
	end

endmodule

`default_nettype wire

// File: sdram_cmd_out.sv
`default_nettype none

`include "sdram_defines.svh"

module sdram_cmd_out (
	input  logic                      clk,
	input  logic                      arst_n,
	input  sdram_cmd_pkg::sdram_cmd_t cmd,
	input  sdram_cmd_pkg::row_t       row,
	input  sdram_cmd_pkg::col_t       col,
	input  sdram_cmd_pkg::bank_t      bank,
	input  logic                      auto_pre,
	input  logic                      write_high,
	input  logic [1:0]                mask,
	input  sdram_req_pkg::word_t      req_wdata,
	output logic                      cs_n,
	output logic                      ras_n,
	output logic                      cas_n,
	output logic                      we_n,
	output logic [12:0]               a,
	output sdram_cmd_pkg::bank_t      ba,
	output logic [1:0]                dqm,
	inout  wire  [15:0]               dq
);
	import sdram_cmd_pkg::*;
	import sdram_req_pkg::*;

	word_t       wdata_stage;   // request data as seen on the accept edge
	word_t       wdata_hold;
	half_t       dq_out;
	logic        dq_oe;
	logic [12:0] pin_a;
	bank_t       pin_ba;

	// ACTIVE is on cmd the cycle after accept, so the stage still has that data
	always_ff @(posedge clk) begin
		wdata_stage <= req_wdata;
		if (cmd == CMD_ACTIVE)
			wdata_hold <= wdata_stage;
		if (cmd == CMD_WRITE)
			dq_out <= write_high ? wdata_hold[31:16] : wdata_hold[15:0];
	end

	always_comb begin
		pin_a  = '0;
		pin_ba = '0;
		case (cmd)
			CMD_ACTIVE: begin
				pin_a  = row;
				pin_ba = bank;
			end
			CMD_READ, CMD_WRITE: begin
				pin_a  = {2'b00, auto_pre, 1'b0, col};  // a10 selects auto-precharge
				pin_ba = bank;
			end
			CMD_PRECHARGE: pin_a[10] = auto_pre;
			CMD_LOAD_MODE: pin_a = `SDRAM_MODE_VALUE;
			default: pin_a = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cs_n                  <= 1'b1;
			{ras_n, cas_n, we_n}  <= CMD_NOP;
			a                     <= '0;
			ba                    <= '0;
			dqm                   <= 2'b00;
			dq_oe                 <= 1'b0;
		end else begin
			cs_n                  <= (cmd == CMD_NOP);   // deselect when idle
			{ras_n, cas_n, we_n}  <= cmd;
			a                     <= pin_a;
			ba                    <= pin_ba;
			dqm                   <= (cmd == CMD_WRITE) ? mask : 2'b00;
			dq_oe                 <= (cmd == CMD_WRITE);
		end
	end

	assign dq = dq_oe ? dq_out : 16'bz;

endmodule

`default_nettype wire

// File: sdram_sequencer.sv
`default_nettype none

`include "sdram_defines.svh"

module sdram_sequencer (
	input  logic                      clk,
	input  logic                      arst_n,
	// request channel
	input  logic                      req_valid,
	input  logic                      req_write,
	input  sdram_req_pkg::word_addr_t req_addr,
	input  sdram_req_pkg::byte_en_t   req_be,
	output logic                      req_ready,
	// startup and refresh timing
	input  logic                      init_done,
	input  logic                      init_tick,
	input  logic [2:0]                init_step,
	input  logic                      refresh_due,
	output logic                      refresh_taken,
	// command towards the pin stage
	output sdram_cmd_pkg::sdram_cmd_t cmd,
	output sdram_cmd_pkg::row_t       row,
	output sdram_cmd_pkg::col_t       col,
	output sdram_cmd_pkg::bank_t      bank,
	output logic                      auto_pre,
	output logic                      write_high,
	output logic                      read_start,
	output logic [1:0]                mask
);
	import sdram_cmd_pkg::*;
	import sdram_req_pkg::*;

	localparam int col_word_bits  = `SDRAM_COL_BITS - 1;
	localparam int wait_bits      = 4;
	localparam int recover_cycles = 3;

	seq_state_t               state;
	logic [wait_bits-1:0]     wait_cnt;
	logic [col_word_bits-1:0] col_word;
	byte_en_t                 be_q;
	logic                     write_q;
	logic                     req_fire;

	assign req_ready = (state == ST_IDLE) && !refresh_due;   // refresh wins over requests
	assign req_fire  = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (req_fire) begin
			row      <= req_addr[col_word_bits + `SDRAM_BANK_BITS +: `SDRAM_ROW_BITS];
			bank     <= req_addr[col_word_bits +: `SDRAM_BANK_BITS];
			col_word <= req_addr[col_word_bits-1:0];
			be_q     <= req_be;
			write_q  <= req_write;
		end
	end

	// -----------------------------------------------------------------------
	// controller FSM, one command per cycle
	// -----------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state         <= ST_STARTUP;
			wait_cnt      <= '0;
			cmd           <= CMD_NOP;
			col           <= '0;
			auto_pre      <= 1'b0;
			write_high    <= 1'b0;
			mask          <= 2'b00;
			read_start    <= 1'b0;
			refresh_taken <= 1'b0;
		end else begin
			cmd           <= CMD_NOP;
			read_start    <= 1'b0;
			refresh_taken <= 1'b0;
			case (state)
				ST_STARTUP: begin
					if (init_tick) begin
						case (init_step)
							3'd1: begin
								cmd      <= CMD_PRECHARGE;
								auto_pre <= 1'b1;     // all banks
							end
							3'd2, 3'd3: cmd <= CMD_AUTO_REFRESH;
							3'd4: cmd <= CMD_LOAD_MODE;
							default: cmd <= CMD_NOP;
						endcase
					end
					if (init_done)
						state <= ST_IDLE;
				end
				ST_IDLE: begin
					if (refresh_due) begin
						cmd           <= CMD_AUTO_REFRESH;
						refresh_taken <= 1'b1;
						wait_cnt      <= wait_bits'(`SDRAM_RFSH_IDLE - 1);
						state         <= ST_RFSH;
					end else if (req_fire) begin
						cmd   <= CMD_ACTIVE;       // row and bank come from the latch
						state <= ST_ACTIVATE_WAIT;
					end
				end
				ST_ACTIVATE_WAIT: state <= ST_RW_LOW;
				ST_RW_LOW: begin
					col        <= {col_word, 1'b0};
					write_high <= 1'b0;
					if (write_q) begin
						cmd      <= CMD_WRITE;
						auto_pre <= 1'b0;
						mask     <= ~be_q[1:0];
					end else begin
						cmd        <= CMD_READ;   // burst of 2 covers both halves
						auto_pre   <= 1'b1;
						mask       <= 2'b00;
						read_start <= 1'b1;
					end
					state <= ST_RW_HIGH;
				end
				ST_RW_HIGH: begin
					if (write_q) begin
						cmd        <= CMD_WRITE;
						col        <= {col_word, 1'b1};
						auto_pre   <= 1'b1;          // closes the row after this beat
						mask       <= ~be_q[3:2];
						write_high <= 1'b1;
					end
					wait_cnt <= wait_bits'(recover_cycles - 1);
					state    <= ST_RECOVER;
				end
				ST_RECOVER, ST_RFSH: begin
					if (wait_cnt == '0)
						state <= ST_IDLE;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sdram_refresh_timer.sv
`default_nettype none

`include "sdram_defines.svh"

module sdram_refresh_timer (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       refresh_taken,
	output logic       init_done,
	output logic [2:0] init_step,
	output logic       init_tick,
	output logic       refresh_due
);

	localparam int cnt_bits = $clog2(`SDRAM_STARTUP_CYCLES + 1);

	// one counter does both jobs: power-up countdown, then age since last refresh
	logic [cnt_bits-1:0] cnt;
	logic [cnt_bits-1:0] tick_at;

	// steps 1..4 fire at 4, 3, 2 and 1 step spacings before the end of the wait
	assign tick_at = cnt_bits'(`SDRAM_INIT_STEP) * (cnt_bits'(4) - cnt_bits'(init_step));

	assign refresh_due = init_done && (cnt > cnt_bits'(`SDRAM_REFRESH_INTERVAL));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt       <= cnt_bits'(`SDRAM_STARTUP_CYCLES - 1);
			init_done <= 1'b0;
			init_step <= '0;
			init_tick <= 1'b0;
		end else begin
			init_tick <= 1'b0;
			if (!init_done) begin
				cnt <= cnt - 1'b1;
				if (init_step < 3'd4 && cnt == tick_at) begin
					init_tick <= 1'b1;
					init_step <= init_step + 3'd1;
				end
				if (cnt == '0) begin
					init_done <= 1'b1;
					// last startup refresh went out two steps ago
					cnt       <= cnt_bits'(2 * `SDRAM_INIT_STEP);
				end
			end else if (refresh_taken) begin
				cnt <= cnt - cnt_bits'(`SDRAM_REFRESH_INTERVAL) + 1'b1; // keeps any lateness
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: sdram_req_pkg.sv
`default_nettype none

`include "sdram_defines.svh"

package sdram_req_pkg;

	// 32-bit word address: {row, bank, column word}
	// the column word drops the half select bit of the device column
	typedef logic [`SDRAM_ROW_BITS+`SDRAM_BANK_BITS+`SDRAM_COL_BITS-2:0] word_addr_t;

	typedef logic [31:0] word_t;
	typedef logic [15:0] half_t;     // one device beat
	typedef logic [3:0]  byte_en_t;  // bit 0 is the lowest byte

endpackage

`default_nettype wire

// File: sdram_cmd_pkg.sv
`default_nettype none

`include "sdram_defines.svh"

package sdram_cmd_pkg;

	// {ras_n, cas_n, we_n} as they go on the pins
	typedef enum logic [2:0] {
		CMD_LOAD_MODE    = 3'b000,
		CMD_AUTO_REFRESH = 3'b001,
		CMD_PRECHARGE    = 3'b010,
		CMD_ACTIVE       = 3'b011,
		CMD_WRITE        = 3'b100,
		CMD_READ         = 3'b101,
		CMD_NOP          = 3'b111
	} sdram_cmd_t;

	// controller FSM
	typedef enum logic [3:0] {
		ST_STARTUP,
		ST_IDLE,
		ST_ACTIVATE_WAIT,  // tRCD gap after ACTIVE
		ST_RW_LOW,
		ST_RW_HIGH,
		ST_RECOVER,        // auto-precharge and tWR drain
		ST_RFSH
	} seq_state_t;

	typedef logic [`SDRAM_ROW_BITS-1:0]  row_t;
	typedef logic [`SDRAM_COL_BITS-1:0]  col_t;   // 16-bit column
	typedef logic [`SDRAM_BANK_BITS-1:0] bank_t;

endpackage

`default_nettype wire

// File: sdram_defines.svh
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// ---------------------------------------------------------------------------
// device timing, in controller clock cycles
// ---------------------------------------------------------------------------

// 100 us power-up hold plus some slack at 100 MHz
`define SDRAM_STARTUP_CYCLES   12100
// 64 ms / 8192 rows at 100 MHz, rounded down
`define SDRAM_REFRESH_INTERVAL 780
`define SDRAM_CAS_LATENCY      2
`define SDRAM_INIT_STEP        8      // spacing of the startup commands
`define SDRAM_RFSH_IDLE        6      // covers tRFC after auto-refresh

// mode register: single write, cas 2, sequential, burst of 2
`define SDRAM_MODE_VALUE       13'h221

// ---------------------------------------------------------------------------
// device geometry
// ---------------------------------------------------------------------------

`define SDRAM_ROW_BITS         13
`define SDRAM_COL_BITS         9
`define SDRAM_BANK_BITS        2

`endif
